/* verilog.f */
+incdir+include
design/fpu_types_pkg.sv
design/float_minmax.sv
design/float_compare.sv
design/fpu_cmp_core.sv
design/fpu_wb_regs.sv
design/fpu_cmp_top.sv
test/fpu_cmp_chk.sv
test/fpu_cmp_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the fpu compare testbench with verilator, run it, then search the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module fpu_cmp_tb \
	-f verilog.f -o fpu_cmp_sim \
	&& ./obj_dir/fpu_cmp_sim > sim.log 2>&1 \
	|| echo "build or simulation run ended with an error"
cat sim.log 2>/dev/null
grep -q "^Done: no errors$" sim.log && echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

/* test/fpu_cmp_cases.txt */
// columns: op a b result flags, op 0 min 1 max 2 cmp 3 neg
// flags: bit 2 unordered, bit 1 equal, bit 0 a less than b, ffff ends the list
0 3C00 BC00 BC00 0
1 3C00 BC00 3C00 0
0 C000 BC00 C000 1
1 C000 BC00 BC00 1
0 3E00 3D00 3D00 0
1 3D00 3E00 3E00 1
0 7C00 4000 4000 0
1 7C00 4000 7C00 0
0 FC00 C000 FC00 1
1 FC00 C000 C000 1
0 7E00 3C00 3C00 4
1 3C00 7C01 3C00 4
0 7C01 FE00 7E00 4
1 FE00 7E00 7E00 4
2 7E00 3C00 0000 4
2 3C00 3C00 0000 2
2 BC00 3C00 0000 1
2 4000 3C00 0000 0
0 0000 8000 8000 2
1 0000 8000 0000 2
0 8000 0000 8000 2
1 8000 0000 0000 2
2 8000 0000 0000 2
3 3C00 0000 BC00 0
3 7E00 0000 FE00 4
3 FC00 0000 7C00 1
3 8000 3C00 0000 1
2 B800 BC00 0000 0
FFFF 0000 0000 0000 0

/* test/fpu_cmp_tb.sv */
`timescale 1ns/1ns
`default_nettype none
`include "fpu_defines.svh"

module fpu_cmp_tb;

	localparam int MAX_CASES = 64;
	// bus cycles or done polls before giving up
	localparam int WAIT_LIMIT = 16;

	logic clk;
	logic rst;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic [`WB_ADR_W-1:0] wb_adr;
	logic [`WB_DAT_W-1:0] wb_dat_w;
	wire [`WB_DAT_W-1:0] wb_dat_r;
	wire wb_ack;

	// five words per case in the order op a b result flags
	logic [15:0] cases_mem [0:MAX_CASES*5-1];
	int errors;
	int tests;
	int failed;

	fpu_cmp_top dut
	(
		.clk(clk), .rst(rst), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
		.wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack)
	);

	bind fpu_wb_regs fpu_cmp_chk u_chk
	(
		.clk(clk), .rst(rst), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_ack(wb_ack),
		.start(start), .done(done), .state(state)
	);

	always #20 clk = ~clk;

	function automatic logic is_nan(input logic [15:0] x);
		return (x[14:10] == 5'h1f) && (x[9:0] != 10'd0);
	endfunction

	// maps non-nan values onto one integer line with -0 just under +0
	function automatic int order_key(input logic [15:0] x);
		int mag;
		mag = {17'd0, x[14:0]};
		if (x[15])
			return -mag - 1;
		return mag;
	endfunction

	function automatic logic [15:0] expected_result(input fpu_types_pkg::fpu_op_e op,
		input logic [15:0] a, input logic [15:0] b);
		logic take_a;
		if (op == fpu_types_pkg::OP_NEG)
			return {~a[15], a[14:0]};
		if (op == fpu_types_pkg::OP_CMP)
			return 16'h0000;
		if (is_nan(a) && is_nan(b))
			return `HALF_NAN;
		if (is_nan(a))
			return b;
		if (is_nan(b))
			return a;
		if (op == fpu_types_pkg::OP_MAX)
			take_a = order_key(a) >= order_key(b);
		else
			take_a = order_key(a) <= order_key(b);
		return take_a ? a : b;
	endfunction

	// flags of a against b packed as unord eq lt from the msb down
	function automatic logic [2:0] compare_flags(input logic [15:0] a, input logic [15:0] b);
		if (is_nan(a) || is_nan(b))
			return 3'b100;
		if ((a == b) || (a[14:0] == 15'd0 && b[14:0] == 15'd0))
			return 3'b010;
		if (order_key(a) < order_key(b))
			return 3'b001;
		return 3'b000;
	endfunction

	// one classic cycle entered on a falling edge and left on the falling edge inside ack
	task automatic wb_transfer(input logic we, input logic [`WB_ADR_W-1:0] adr,
		input logic [`WB_DAT_W-1:0] wdata, output logic [`WB_DAT_W-1:0] rdata,
		output logic ok);
		int count;
		ok = 1'b0;
		count = 0;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = we;
		wb_adr = adr;
		wb_dat_w = wdata;
		while (!ok && count < WAIT_LIMIT)
		begin
			@(negedge clk);
			ok = wb_ack;
			count++;
		end
		// read data is only valid while ack is up
		rdata = wb_dat_r;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		if (!ok)
		begin
			$display("bus access to word %0d got no ack", adr);
			errors++;
		end
	endtask

	task automatic read_expect(input logic [`WB_ADR_W-1:0] adr, input logic [31:0] expected,
		input string name);
		logic [31:0] data;
		logic ok;
		wb_transfer(1'b0, adr, '0, data, ok);
		if (ok && data !== expected)
		begin
			$display("ERR %s expected %h got %h", name, expected, data);
			errors++;
		end
	endtask

	task automatic run_case(input string name, input fpu_types_pkg::fpu_op_e op,
		input logic [15:0] a, input logic [15:0] b, input logic [15:0] exp_result,
		input logic [2:0] exp_flags);
		logic [31:0] data;
		logic ok;
		int polls;
		int errors_before;
		errors_before = errors;
		tests++;
		wb_transfer(1'b1, fpu_types_pkg::REG_OPA, {16'h0, a}, data, ok);
		if (ok)
			wb_transfer(1'b1, fpu_types_pkg::REG_OPB, {16'h0, b}, data, ok);
		if (ok)
			wb_transfer(1'b1, fpu_types_pkg::REG_CTRL, {30'h0, op}, data, ok);
		// done sits in bit 0 of ctrl
		polls = 0;
		data = '0;
		while (ok && !data[0] && polls < WAIT_LIMIT)
		begin
			wb_transfer(1'b0, fpu_types_pkg::REG_CTRL, '0, data, ok);
			polls++;
		end
		if (ok && !data[0])
		begin
			$display("done bit stayed low for %0d polls", polls);
			errors++;
			ok = 1'b0;
		end
		if (ok)
			wb_transfer(1'b0, fpu_types_pkg::REG_RESULT, '0, data, ok);
		if (ok && data[15:0] !== exp_result)
		begin
			$display("ERR result expected %h got %h", exp_result, data[15:0]);
			errors++;
		end
		// flags read as unord eq lt from bit 18 down
		if (ok && data[18:16] !== exp_flags)
		begin
			$display("ERR flags expected %h got %h", exp_flags, data[18:16]);
			errors++;
		end
		// nothing above the flags
		if (ok && data[31:19] !== 13'h0)
		begin
			$display("ERR wb_dat_r[31:19] expected %h got %h", 13'h0, data[31:19]);
			errors++;
		end
		if (errors != errors_before)
			failed++;
		$display("%s %s a=%h b=%h %s", name, op.name(), a, b,
			(errors == errors_before) ? "passed" : "FAILED");
	endtask

	initial
	begin
		logic [31:0] rnd;
		logic [31:0] data;
		logic [15:0] a;
		logic [15:0] b;
		logic ok;
		int idx;
		int errors_before;
		void'($urandom(32'h3733));
		clk = 1'b0;
		rst = 1'b1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		errors = 0;
		tests = 0;
		failed = 0;
		$readmemh("test/fpu_cmp_cases.txt", cases_mem);
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		// register block straight out of reset and then operand readback
		errors_before = errors;
		tests++;
		read_expect(fpu_types_pkg::REG_CTRL, 32'h0, "done");
		read_expect(fpu_types_pkg::REG_OPA, 32'h0, "opa");
		wb_transfer(1'b1, fpu_types_pkg::REG_OPA, 32'hFFFF1234, data, ok);
		wb_transfer(1'b1, fpu_types_pkg::REG_OPB, 32'h0000ABCD, data, ok);
		read_expect(fpu_types_pkg::REG_OPA, 32'h00001234, "opa");
		read_expect(fpu_types_pkg::REG_OPB, 32'h0000ABCD, "opb");
		if (errors != errors_before)
			failed++;
		$display("register access %s", (errors == errors_before) ? "passed" : "FAILED");

		// directed cases until an ffff opcode ends the list
		idx = 0;
		while (idx < MAX_CASES && cases_mem[idx*5] != 16'hFFFF)
		begin
			run_case($sformatf("case %0d", idx),
				fpu_types_pkg::fpu_op_e'(cases_mem[idx*5][1:0]), cases_mem[idx*5+1],
				cases_mem[idx*5+2], cases_mem[idx*5+3], cases_mem[idx*5+4][2:0]);
			idx++;
		end

		// random operand pairs through min, max and compare
		for (int pair = 0; pair < 8; pair++)
		begin
			rnd = $urandom;
			a = rnd[15:0];
			b = rnd[31:16];
			run_case("random", fpu_types_pkg::OP_MIN, a, b,
				expected_result(fpu_types_pkg::OP_MIN, a, b), compare_flags(a, b));
			run_case("random", fpu_types_pkg::OP_MAX, a, b,
				expected_result(fpu_types_pkg::OP_MAX, a, b), compare_flags(a, b));
			run_case("random", fpu_types_pkg::OP_CMP, a, b,
				expected_result(fpu_types_pkg::OP_CMP, a, b), compare_flags(a, b));
		end

		// done stays readable once an operation has run
		errors_before = errors;
		tests++;
		read_expect(fpu_types_pkg::REG_CTRL, 32'h1, "done");
		if (errors != errors_before)
			failed++;
		$display("done after operation %s", (errors == errors_before) ? "passed" : "FAILED");

		$display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire

/* test/fpu_cmp_chk.sv */
`timescale 1ns/1ns
`default_nettype none

module fpu_cmp_chk
(
	input wire clk,
	input wire rst,
	input wire wb_cyc,
	input wire wb_stb,
	input wire wb_ack,
	input wire start,
	input wire done,
	input wire fpu_types_pkg::wb_state_e state
);

	// ack never stretches past one cycle
	ack_single: assert property (@(posedge clk) disable iff (rst) wb_ack |=> !wb_ack)
		else $error("wb_ack high for more than one cycle");

	// every ack answers a request the slave took while idle
	ack_after_request: assert property (@(posedge clk) disable iff (rst)
		wb_ack |-> $past(wb_cyc && wb_stb && state == fpu_types_pkg::WB_IDLE))
		else $error("wb_ack without a request taken in the idle state");

	// core answers on the edge after start
	done_after_start: assert property (@(posedge clk) disable iff (rst) start |=> done)
		else $error("done not high one cycle after start");

	done_rise: assert property (@(posedge clk) disable iff (rst) $rose(done) |-> $past(start))
		else $error("done rose without a start one cycle earlier");

	// start only fires together with the ack of a ctrl write
	start_in_ack: assert property (@(posedge clk) disable iff (rst) start |-> wb_ack)
		else $error("start high outside an ack cycle");

endmodule

`default_nettype wire

/* design/fpu_cmp_top.sv */
`timescale 1ns/1ns
`default_nettype none
`include "fpu_defines.svh"

module fpu_cmp_top
(
	input wire clk,
	input wire rst,
	input wire wb_cyc,
	input wire wb_stb,
	input wire wb_we,
	input wire [`WB_ADR_W-1:0] wb_adr,
	input wire [`WB_DAT_W-1:0] wb_dat_w,
	output logic [`WB_DAT_W-1:0] wb_dat_r,
	output logic wb_ack
);

	// register block to core
	logic start;
	fpu_types_pkg::fpu_op_e op;
	logic [`HALF_FLOAT_W-1:0] opa, opb;
	// core back to register block
	logic done, lt, eq, unord;
	logic [`HALF_FLOAT_W-1:0] result;

	fpu_wb_regs u_regs
	(
		.clk(clk), .rst(rst),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
		.start(start), .op(op), .opa(opa), .opb(opb),
		.done(done), .result(result), .lt(lt), .eq(eq), .unord(unord)
	);

	fpu_cmp_core u_core
	(
		.clk(clk), .rst(rst),
		.start(start), .op(op), .opa(opa), .opb(opb),
		.done(done), .result(result), .lt(lt), .eq(eq), .unord(unord)
	);

endmodule

`default_nettype wire

/* design/fpu_wb_regs.sv */
`timescale 1ns/1ns
`default_nettype none
`include "fpu_defines.svh"

module fpu_wb_regs
(
	input wire clk,
	input wire rst,
	// wishbone classic slave
	input wire wb_cyc,
	input wire wb_stb,
	input wire wb_we,
	input wire [`WB_ADR_W-1:0] wb_adr,
	input wire [`WB_DAT_W-1:0] wb_dat_w,
	output logic [`WB_DAT_W-1:0] wb_dat_r,
	output logic wb_ack,
	// towards the compare core
	output logic start,
	output fpu_types_pkg::fpu_op_e op,
	output logic [`HALF_FLOAT_W-1:0] opa,
	output logic [`HALF_FLOAT_W-1:0] opb,
	input wire done,
	input wire [`HALF_FLOAT_W-1:0] result,
	input wire lt,
	input wire eq,
	input wire unord
);

	fpu_types_pkg::wb_state_e state;
	fpu_types_pkg::reg_addr_e addr;
	logic accept;
	logic [`WB_DAT_W-1:0] read_data;

	assign addr = fpu_types_pkg::reg_addr_e'(wb_adr);

	// a request is taken only from idle, so every access is two cycles
	assign accept = wb_cyc & wb_stb & (state == fpu_types_pkg::WB_IDLE);
	assign wb_ack = (state == fpu_types_pkg::WB_ACK);

	// read mux, sampled on the edge that raises ack
	always_comb
	begin
		case (addr)
			fpu_types_pkg::REG_OPA: read_data = {{(`WB_DAT_W-`HALF_FLOAT_W){1'b0}}, opa};
			fpu_types_pkg::REG_OPB: read_data = {{(`WB_DAT_W-`HALF_FLOAT_W){1'b0}}, opb};
			fpu_types_pkg::REG_CTRL: read_data = {{(`WB_DAT_W-1){1'b0}}, done};
			// flags sit just above the 16 bit result
			fpu_types_pkg::REG_RESULT:
				read_data = {{(`WB_DAT_W-`HALF_FLOAT_W-3){1'b0}}, unord, eq, lt, result};
			default: read_data = '0;
		endcase
	end

	// ack state machine, never stalls
	always_ff @(posedge clk)
	begin
		if (rst)
			state <= fpu_types_pkg::WB_IDLE;
		else if (state == fpu_types_pkg::WB_ACK)
			state <= fpu_types_pkg::WB_IDLE;
		else if (accept)
			state <= fpu_types_pkg::WB_ACK;
	end

	// register file
	// writes are taken on the edge into ack so they are visible during the ack cycle
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			opa <= '0;
			opb <= '0;
			op <= fpu_types_pkg::OP_MIN;
			start <= 1'b0;
			wb_dat_r <= '0;
		end
		else
		begin
			// start is a single pulse lined up with ack
			start <= accept & wb_we & (addr == fpu_types_pkg::REG_CTRL);
			if (accept)
			begin
				wb_dat_r <= read_data;
				if (wb_we)
				begin
					case (addr)
						fpu_types_pkg::REG_OPA: opa <= wb_dat_w[`HALF_FLOAT_W-1:0];
						fpu_types_pkg::REG_OPB: opb <= wb_dat_w[`HALF_FLOAT_W-1:0];
						fpu_types_pkg::REG_CTRL: op <= fpu_types_pkg::fpu_op_e'(wb_dat_w[1:0]);
						// result is read only
						default: ;
					endcase
				end
			end
		end
	end

endmodule

`default_nettype wire

/* design/fpu_cmp_core.sv */
`timescale 1ns/1ns
`default_nettype none
`include "fpu_defines.svh"

module fpu_cmp_core
(
	input wire clk,
	input wire rst,
	input wire start,
	input wire fpu_types_pkg::fpu_op_e op,
	input wire [`HALF_FLOAT_W-1:0] opa,
	input wire [`HALF_FLOAT_W-1:0] opb,
	output logic done,
	output logic [`HALF_FLOAT_W-1:0] result,
	output logic lt,
	output logic eq,
	output logic unord
);

	logic sel_max;
	logic [`HALF_FLOAT_W-1:0] sel_out;
	logic cmp_lt, cmp_eq, cmp_unord;

	// the selector serves both min and max
	assign sel_max = (op == fpu_types_pkg::OP_MAX);

	float_minmax u_minmax
	(
		.float1(opa),
		.float2(opb),
		.max(sel_max),
		.out(sel_out)
	);

	float_compare u_compare
	(
		.float1(opa),
		.float2(opb),
		.lt(cmp_lt),
		.eq(cmp_eq),
		.unord(cmp_unord)
	);

	// one cycle op: everything lands on the edge closing the start cycle
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			done <= 1'b0;
			result <= '0;
			lt <= 1'b0;
			eq <= 1'b0;
			unord <= 1'b0;
		end
		else if (start)
		begin
			// done stays up until reset, each start refreshes result and flags
			done <= 1'b1;
			lt <= cmp_lt;
			eq <= cmp_eq;
			unord <= cmp_unord;
			case (op)
				fpu_types_pkg::OP_MIN: result <= sel_out;
				fpu_types_pkg::OP_MAX: result <= sel_out;
				// only the flags carry the answer for a compare
				fpu_types_pkg::OP_CMP: result <= '0;
				// sign flip only, nan payload and inf pass through
				fpu_types_pkg::OP_NEG: result <= {~opa[`HALF_FLOAT_W-1], opa[`HALF_FLOAT_W-2:0]};
				default: result <= '0;
			endcase
		end
	end

endmodule

`default_nettype wire

/* design/float_compare.sv */
`timescale 1ns/1ns
`default_nettype none
`include "fpu_defines.svh"

module float_compare
(
	input wire [`HALF_FLOAT_W-1:0] float1,
	input wire [`HALF_FLOAT_W-1:0] float2,
	// float1 strictly below float2
	output logic lt,
	output logic eq,
	// at least one operand is nan
	output logic unord
);

	localparam int SIGN_BIT = `HALF_FLOAT_W - 1;
	localparam int EXP_LSB = `HALF_FRACTION_W;
	localparam int EXP_MSB = EXP_LSB + `HALF_EXPONENT_W - 1;

	logic float1_sign, float2_sign;
	// exponent and fraction together order like an unsigned integer
	logic [SIGN_BIT-1:0] float1_mag, float2_mag;
	logic float1_nan, float2_nan;
	logic both_zero;
	logic signed_lt;

	assign float1_sign = float1[SIGN_BIT];
	assign float2_sign = float2[SIGN_BIT];
	assign float1_mag = float1[SIGN_BIT-1:0];
	assign float2_mag = float2[SIGN_BIT-1:0];

	assign float1_nan = (&float1[EXP_MSB:EXP_LSB]) & (|float1[EXP_LSB-1:0]);
	assign float2_nan = (&float2[EXP_MSB:EXP_LSB]) & (|float2[EXP_LSB-1:0]);

	// +0 and -0 are one value here
	assign both_zero = ~(|float1_mag) & ~(|float2_mag);

	always_comb
	begin
		// same sign rule as the min/max selector
		if (float1_sign != float2_sign)
			signed_lt = float1_sign;
		else if (float1_sign)
			signed_lt = float1_mag > float2_mag;
		else
			signed_lt = float1_mag < float2_mag;
	end

	// unordered masks both other flags
	assign unord = float1_nan | float2_nan;
	assign eq = ~unord & ((float1 == float2) | both_zero);
	// eq mask keeps -0 < +0 from showing up as less-than
	assign lt = ~unord & ~eq & signed_lt;

endmodule

`default_nettype wire

/* design/float_minmax.sv */
`timescale 1ns/1ns
`default_nettype none
`include "fpu_defines.svh"

module float_minmax
(
	input wire [`HALF_FLOAT_W-1:0] float1,
	input wire [`HALF_FLOAT_W-1:0] float2,
	// high picks the larger operand, low the smaller
	input wire max,
	output logic [`HALF_FLOAT_W-1:0] out
);

	// field positions inside a half
	localparam int SIGN_BIT = `HALF_FLOAT_W - 1;
	localparam int EXP_LSB = `HALF_FRACTION_W;
	localparam int EXP_MSB = EXP_LSB + `HALF_EXPONENT_W - 1;

	logic float1_sign, float2_sign;
	logic [`HALF_EXPONENT_W-1:0] float1_exponent, float2_exponent;
	logic [`HALF_FRACTION_W-1:0] float1_fraction, float2_fraction;
	logic float1_nan, float2_nan;
	// magnitude order, sign ignored
	logic mag1_gt, mag2_gt;
	// signed order of the two operands
	logic float1_lt;

	assign float1_sign = float1[SIGN_BIT];
	assign float2_sign = float2[SIGN_BIT];
	assign float1_exponent = float1[EXP_MSB:EXP_LSB];
	assign float2_exponent = float2[EXP_MSB:EXP_LSB];
	assign float1_fraction = float1[EXP_LSB-1:0];
	assign float2_fraction = float2[EXP_LSB-1:0];

	// nan: exponent saturated and some fraction bit set
	assign float1_nan = (&float1_exponent) & (|float1_fraction);
	assign float2_nan = (&float2_exponent) & (|float2_fraction);

	always_comb
	begin
		// exponent decides first, fraction only breaks a tie
		if (float1_exponent != float2_exponent)
		begin
			mag1_gt = float1_exponent > float2_exponent;
			mag2_gt = float2_exponent > float1_exponent;
		end
		else
		begin
			mag1_gt = float1_fraction > float2_fraction;
			mag2_gt = float2_fraction > float1_fraction;
		end
		// differing signs: the negative one is lower, so -0 sits under +0
		// both negative: the bigger magnitude is the lower value
		if (float1_sign != float2_sign)
			float1_lt = float1_sign;
		else if (float1_sign)
			float1_lt = mag1_gt;
		else
			float1_lt = mag2_gt;
		// nan cases win over the numeric order
		if (float1_nan && float2_nan)
			out = `HALF_NAN;
		else if (float1_nan)
			out = float2;
		else if (float2_nan)
			out = float1;
		else if (max)
			out = float1_lt ? float2 : float1;
		else
			out = float1_lt ? float1 : float2;
	end

endmodule

`default_nettype wire

/* design/fpu_types_pkg.sv */
`default_nettype none

package fpu_types_pkg;

	// operation codes written to the low bits of ctrl
	typedef enum logic [1:0]
	{
		OP_MIN = 2'd0,
		OP_MAX = 2'd1,
		OP_CMP = 2'd2,
		OP_NEG = 2'd3
	} fpu_op_e;

	// word addresses on the bus
	// result is read only, writes to it are dropped
	typedef enum logic [1:0]
	{
		REG_OPA = 2'd0,
		REG_OPB = 2'd1,
		REG_CTRL = 2'd2,
		REG_RESULT = 2'd3
	} reg_addr_e;

	// slave handshake state
	// ack is high for the whole WB_ACK cycle
	typedef enum logic
	{
		WB_IDLE = 1'b0,
		WB_ACK = 1'b1
	} wb_state_e;

endpackage

`default_nettype wire

/* include/fpu_defines.svh */
`ifndef FPU_DEFINES_SVH
`define FPU_DEFINES_SVH

// half precision layout: sign, 5 bit exponent, 10 bit fraction
`define HALF_FLOAT_W 16
`define HALF_EXPONENT_W 5
`define HALF_FRACTION_W 10

// special encodings
// quiet nan with only the top fraction bit set
`define HALF_NAN 16'h7E00
`define HALF_INF 16'h7C00
`define HALF_INFN 16'hFC00

// wishbone word address and data widths
// four word registers in the map
`define WB_ADR_W 2
`define WB_DAT_W 32

`endif
